// ==== project.f ====
+incdir+verilog
verilog/issue_pkg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/scoreboard.sv
verilog/issue_stage.sv
verilog/execute_units.sv
verilog/pipeline_top.sv
tests/tb_pipeline.sv

// ==== tests/tb_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_defines.svh"

module tb_pipeline;

    typedef struct packed {
        logic [2:0]  test;
        logic        check;
        logic [4:0]  dest;
        logic [31:0] word;
    } entry_t;

    logic              clock;
    logic              reset;
    issue_pkg::instr_t instr;
    logic              instr_valid;
    logic              stall;
    issue_pkg::wb_t    wb_alu;
    issue_pkg::wb_t    wb_mem;
    issue_pkg::wb_t    wb_mul;
    logic [4:0]        debug_addr;
    logic [31:0]       debug_data;

    entry_t      program_table [$];
    logic [31:0] shadow_regs [`ISSUE_NUM_REGS];
    logic [31:0] shadow_mem [`ISSUE_DMEM_WORDS];
    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          stall_cycles;
    int          mem_pulses;
    int          mul_pulses;
    int          mul_back_to_back;
    int          zero_writes;
    logic        mul_prev;

    pipeline_top DUT (
        .clock       (clock),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .wb_alu      (wb_alu),
        .wb_mem      (wb_mem),
        .wb_mul      (wb_mul),
        .debug_addr  (debug_addr),
        .debug_data  (debug_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Pipeline activity sampled mid-cycle, where outputs are settled
    always @(negedge clock) begin
        if (reset) begin
            if (stall) begin
                stall_cycles++;
            end
            if (wb_mem.valid) begin
                mem_pulses++;
            end
            if (wb_mul.valid) begin
                mul_pulses++;
                if (mul_prev) begin
                    mul_back_to_back++;
                end
            end
            if ((wb_alu.valid && wb_alu.addr == 5'd0) || (wb_mem.valid && wb_mem.addr == 5'd0) ||
                (wb_mul.valid && wb_mul.addr == 5'd0)) begin
                zero_writes++;
            end
            mul_prev = wb_mul.valid;
        end
    end

    function automatic logic [31:0] random_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits of the LCG are the better mixed ones
    function automatic logic [15:0] random_imm();
        logic [31:0] r;
        r = random_word();
        return r[31:16];
    endfunction

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] shamt,
                                             input logic [5:0] funct);
        return {issue_pkg::op_special, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void add_entry(input logic [2:0] test, input logic [31:0] word,
                                      input logic check, input logic [4:0] dest);
        entry_t e;
        e.test  = test;
        e.check = check;
        e.dest  = dest;
        e.word  = word;
        program_table.push_back(e);
    endfunction

    task automatic build_program();
        logic [15:0] base;
        logic [15:0] shift;
        // Test 2, immediates then register-register ALU ops
        add_entry(2, encode_i(issue_pkg::op_addiu, 5'd0, 5'd1, random_imm()), 1'b1, 5'd1);
        add_entry(2, encode_i(issue_pkg::op_ori, 5'd0, 5'd2, random_imm()), 1'b1, 5'd2);
        add_entry(2, encode_i(issue_pkg::op_addiu, 5'd1, 5'd3, random_imm()), 1'b1, 5'd3);
        add_entry(2, encode_i(issue_pkg::op_ori, 5'd2, 5'd4, random_imm()), 1'b1, 5'd4);
        add_entry(2, encode_r(5'd1, 5'd2, 5'd5, 5'd0, issue_pkg::fn_addu), 1'b1, 5'd5);
        add_entry(2, encode_r(5'd3, 5'd4, 5'd6, 5'd0, issue_pkg::fn_subu), 1'b1, 5'd6);
        add_entry(2, encode_r(5'd1, 5'd4, 5'd7, 5'd0, issue_pkg::fn_and), 1'b1, 5'd7);
        add_entry(2, encode_r(5'd2, 5'd3, 5'd8, 5'd0, issue_pkg::fn_or), 1'b1, 5'd8);
        add_entry(2, encode_r(5'd5, 5'd6, 5'd9, 5'd0, issue_pkg::fn_slt), 1'b1, 5'd9);
        add_entry(2, encode_r(5'd6, 5'd5, 5'd10, 5'd0, issue_pkg::fn_slt), 1'b1, 5'd10);
        shift = random_imm();
        add_entry(2, encode_r(5'd0, 5'd3, 5'd11, shift[4:0], issue_pkg::fn_sll), 1'b1, 5'd11);
        // Test 3, stores and loads around a random base word
        base = random_imm();
        add_entry(3, encode_i(issue_pkg::op_addiu, 5'd0, 5'd12, {10'd0, base[5:0]}), 1'b1, 5'd12);
        add_entry(3, encode_i(issue_pkg::op_sw, 5'd12, 5'd5, 16'd0), 1'b0, 5'd0);
        add_entry(3, encode_i(issue_pkg::op_sw, 5'd12, 5'd8, 16'd9), 1'b0, 5'd0);
        add_entry(3, encode_i(issue_pkg::op_lw, 5'd12, 5'd13, 16'd0), 1'b1, 5'd13);
        add_entry(3, encode_i(issue_pkg::op_lw, 5'd12, 5'd14, 16'd9), 1'b1, 5'd14);
        add_entry(3, encode_i(issue_pkg::op_sw, 5'd12, 5'd6, 16'd0), 1'b0, 5'd0);
        add_entry(3, encode_i(issue_pkg::op_lw, 5'd12, 5'd15, 16'd0), 1'b1, 5'd15);
        // Test 4, independent multiplies back to back
        add_entry(4, encode_r(5'd1, 5'd2, 5'd16, 5'd0, issue_pkg::fn_mult), 1'b1, 5'd16);
        add_entry(4, encode_r(5'd3, 5'd4, 5'd17, 5'd0, issue_pkg::fn_mult), 1'b1, 5'd17);
        add_entry(4, encode_r(5'd5, 5'd6, 5'd18, 5'd0, issue_pkg::fn_mult), 1'b1, 5'd18);
        add_entry(4, encode_r(5'd7, 5'd8, 5'd19, 5'd0, issue_pkg::fn_mult), 1'b1, 5'd19);
        // Test 5, RAW on load and multiply results, then WAW from mul to alu
        add_entry(5, encode_i(issue_pkg::op_lw, 5'd12, 5'd20, 16'd9), 1'b1, 5'd20);
        add_entry(5, encode_r(5'd20, 5'd1, 5'd21, 5'd0, issue_pkg::fn_addu), 1'b1, 5'd21);
        add_entry(5, encode_r(5'd21, 5'd3, 5'd22, 5'd0, issue_pkg::fn_mult), 1'b1, 5'd22);
        add_entry(5, encode_r(5'd22, 5'd2, 5'd23, 5'd0, issue_pkg::fn_subu), 1'b1, 5'd23);
        add_entry(5, encode_r(5'd4, 5'd5, 5'd24, 5'd0, issue_pkg::fn_mult), 1'b0, 5'd24);
        add_entry(5, encode_i(issue_pkg::op_addiu, 5'd1, 5'd24, random_imm()), 1'b1, 5'd24);
        add_entry(5, encode_r(5'd24, 5'd23, 5'd25, 5'd0, issue_pkg::fn_or), 1'b1, 5'd25);
        // Test 6, every unit aimed at r0, then r0 read as a source
        add_entry(6, encode_i(issue_pkg::op_addiu, 5'd1, 5'd0, random_imm()), 1'b0, 5'd0);
        add_entry(6, encode_i(issue_pkg::op_ori, 5'd2, 5'd0, random_imm()), 1'b0, 5'd0);
        add_entry(6, encode_r(5'd1, 5'd2, 5'd0, 5'd0, issue_pkg::fn_mult), 1'b0, 5'd0);
        add_entry(6, encode_i(issue_pkg::op_lw, 5'd12, 5'd0, 16'd0), 1'b0, 5'd0);
        add_entry(6, encode_r(5'd1, 5'd2, 5'd0, 5'd0, issue_pkg::fn_or), 1'b1, 5'd0);
        add_entry(6, encode_r(5'd0, 5'd3, 5'd26, 5'd0, issue_pkg::fn_addu), 1'b1, 5'd26);
    endtask

    // Architectural effect of one instruction on the shadow state
    task automatic model_exec(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] index;
        logic [31:0] result;
        logic [4:0]  dst;
        logic        wr;
        a      = shadow_regs[w[25:21]];
        b      = shadow_regs[w[20:16]];
        sext   = {{16{w[15]}}, w[15:0]};
        index  = (a + sext) % `ISSUE_DMEM_WORDS;
        result = 32'h0000_0000;
        dst    = w[20:16];
        wr     = 1'b1;
        case (w[31:26])
            issue_pkg::op_special: begin
                dst = w[15:11];
                case (w[5:0])
                    issue_pkg::fn_addu: result = a + b;
                    issue_pkg::fn_subu: result = a - b;
                    issue_pkg::fn_and:  result = a & b;
                    issue_pkg::fn_or:   result = a | b;
                    issue_pkg::fn_slt:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    issue_pkg::fn_sll:  result = b << w[10:6];
                    issue_pkg::fn_mult: result = a * b;
                    default:            wr = 1'b0;
                endcase
            end
            issue_pkg::op_addiu: result = a + sext;
            issue_pkg::op_ori:   result = a | {16'h0000, w[15:0]};
            issue_pkg::op_lw:    result = shadow_mem[index];
            issue_pkg::op_sw: begin
                wr = 1'b0;
                shadow_mem[index] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            shadow_regs[dst] = result;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $finish;
    endtask

    // Holds the word on the inputs until decode takes it
    task automatic issue_instr(input logic [31:0] word);
        int waited;
        waited = 0;
        instr = word;
        instr_valid = 1'b1;
        @(negedge clock);
        while (stall) begin
            waited++;
            if (waited > 50) begin
                abort_run("Stall stayed high for 50 cycles while an instruction waited");
            end
            @(negedge clock);
        end
        @(posedge clock);
        #1;
    endtask

    // Drained once nothing stalls or writes back for eight cycles
    task automatic wait_idle();
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < 8) begin
            @(negedge clock);
            waited++;
            if (stall || wb_alu.valid || wb_mem.valid || wb_mul.valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (waited > 100) begin
                abort_run("Pipeline did not drain within 100 cycles");
            end
        end
    endtask

    task automatic check_reg(input logic [4:0] addr, input logic [31:0] expected);
        logic [31:0] actual;
        @(posedge clock);
        #1;
        debug_addr = addr;
        @(negedge clock);
        actual = debug_data;
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED debug_data r%0d: expected %h, actual %h", addr, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic start_test();
        @(posedge clock);
        #1;
        stall_cycles     = 0;
        mem_pulses       = 0;
        mul_pulses       = 0;
        mul_back_to_back = 0;
        zero_writes      = 0;
    endtask

    function automatic string test_name(input int t);
        case (t)
            2:       return "alu immediates and register ops";
            3:       return "stores and loads";
            4:       return "back-to-back multiplies";
            5:       return "dependent chains";
            default: return "writes to r0";
        endcase
    endfunction

    initial begin
        int first_error;
        int first_check;
        int loads;
        int mults;
        reset       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        debug_addr  = 5'd0;
        lcg_state   = 32'hb16eb284;
        checks      = 0;
        errors      = 0;
        mul_prev    = 1'b0;
        for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
            shadow_regs[i] = 32'h0000_0000;
        end
        build_program();
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b1;

        // Test 1, state right after reset
        start_test();
        @(negedge clock);
        check_flag("stall", stall, 1'b0);
        check_flag("wb_alu.valid", wb_alu.valid, 1'b0);
        check_flag("wb_mem.valid", wb_mem.valid, 1'b0);
        check_flag("wb_mul.valid", wb_mul.valid, 1'b0);
        for (int r = 0; r < `ISSUE_NUM_REGS; r++) begin
            check_reg(r[4:0], 32'h0000_0000);
        end
        $display("Test 1 reset state: %0d checks, %0d errors", checks, errors);

        for (int t = 2; t <= 6; t++) begin
            start_test();
            first_error = errors;
            first_check = checks;
            loads = 0;
            mults = 0;
            foreach (program_table[k]) begin
                if (program_table[k].test == t) begin
                    model_exec(program_table[k].word);
                    issue_instr(program_table[k].word);
                    if (program_table[k].word[31:26] == issue_pkg::op_lw &&
                        program_table[k].word[20:16] != 5'd0) begin
                        loads++;
                    end
                    if (program_table[k].word[31:26] == issue_pkg::op_special &&
                        program_table[k].word[5:0] == issue_pkg::fn_mult &&
                        program_table[k].word[15:11] != 5'd0) begin
                        mults++;
                    end
                end
            end
            instr_valid = 1'b0;
            wait_idle();
            foreach (program_table[k]) begin
                if (program_table[k].test == t && program_table[k].check) begin
                    check_reg(program_table[k].dest, shadow_regs[program_table[k].dest]);
                end
            end
            checks++;
            if (mem_pulses != loads) begin
                errors++;
                $display("FAILED wb_mem pulse count: expected %h, actual %h", loads, mem_pulses);
            end
            if (mul_pulses != mults) begin
                errors++;
                $display("FAILED wb_mul pulse count: expected %h, actual %h", mults, mul_pulses);
            end
            if (t == 4 && mul_back_to_back == 0) begin
                errors++;
                $display("No two wb_mul pulses arrived in consecutive cycles");
            end
            if (t == 5 && stall_cycles == 0) begin
                errors++;
                $display("Stall never went high during the dependent chains");
            end
            if (t == 6 && zero_writes != 0) begin
                errors++;
                $display("A writeback port pulsed with addr 0 in %0d cycles", zero_writes);
            end
            $display("Test %0d %s: %0d checks, %0d errors", t, test_name(t),
                     checks - first_check, errors - first_error);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  issue_pkg::instr_t    instr,
    input  logic                 instr_valid,
    input  logic                 stall,
    output logic [4:0]           addr_a,
    output logic [4:0]           addr_b,
    input  logic [31:0]          data_a,
    input  logic [31:0]          data_b,
    output issue_pkg::dec_iss_t  dec,
    output logic [31:0]          reg_a,
    output logic [31:0]          reg_b
);

    issue_pkg::instr_t ir;
    logic              ir_valid;
    logic [31:0]       imm_sign;
    logic [31:0]       imm_zero;

    // Instruction register holds its word while issue stalls
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ir_valid <= 1'b0;
        end else if (!stall) begin
            ir_valid <= instr_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall && instr_valid) begin
            ir <= instr;
        end
    end

    assign imm_sign = {{16{ir.i.imm16[15]}}, ir.i.imm16};
    assign imm_zero = {16'h0000, ir.i.imm16};

    // Operands are read straight from rs and rt
    assign addr_a = ir.r.rs;
    assign addr_b = ir.r.rt;
    assign reg_a  = data_a;
    assign reg_b  = data_b;

    always_comb begin
        dec           = '0;
        dec.valid     = ir_valid;
        dec.op        = ir.r.op;
        dec.funct     = ir.r.funct;
        dec.addr_a    = ir.r.rs;
        dec.addr_b    = ir.r.rt;
        dec.shamt     = ir.r.shamt;
        dec.alu_op    = issue_pkg::alu_add;
        dec.imm_ext   = imm_sign;
        case (ir.r.op)
            issue_pkg::op_special: begin
                dec.uses_b    = 1'b1;
                dec.dest      = ir.r.rd;
                dec.write_reg = 1'b1;
                case (ir.r.funct)
                    issue_pkg::fn_addu: dec.alu_op = issue_pkg::alu_add;
                    issue_pkg::fn_subu: dec.alu_op = issue_pkg::alu_sub;
                    issue_pkg::fn_and:  dec.alu_op = issue_pkg::alu_and;
                    issue_pkg::fn_or:   dec.alu_op = issue_pkg::alu_or;
                    issue_pkg::fn_slt:  dec.alu_op = issue_pkg::alu_slt;
                    issue_pkg::fn_sll:  dec.alu_op = issue_pkg::alu_sll;
                    // Multiplier takes no ALU operation
                    issue_pkg::fn_mult: ;
                    default:            dec.write_reg = 1'b0;
                endcase
            end
            issue_pkg::op_addiu: begin
                dec.sel_imm   = 1'b1;
                dec.dest      = ir.i.rt;
                dec.write_reg = 1'b1;
            end
            issue_pkg::op_ori: begin
                dec.sel_imm   = 1'b1;
                dec.imm_ext   = imm_zero;
                dec.alu_op    = issue_pkg::alu_or;
                dec.dest      = ir.i.rt;
                dec.write_reg = 1'b1;
            end
            issue_pkg::op_lw: begin
                dec.read_mem  = 1'b1;
                dec.dest      = ir.i.rt;
                dec.write_reg = 1'b1;
            end
            issue_pkg::op_sw: begin
                dec.write_mem = 1'b1;
                dec.uses_b    = 1'b1;
            end
            default: ;
        endcase
        // Writes to r0 are dropped here
        if (dec.dest == 5'd0) begin
            dec.write_reg = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/execute_units.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_defines.svh"

module execute_units (
    input  logic                clock,
    input  logic                reset,
    input  issue_pkg::iss_ex_t  iss,
    output issue_pkg::wb_t      wb_alu,
    output issue_pkg::wb_t      wb_mem,
    output issue_pkg::wb_t      wb_mul
);

    localparam int dmem_aw = $clog2(`ISSUE_DMEM_WORDS);

    logic [31:0]        alu_b;
    logic [31:0]        alu_result;
    logic [31:0]        mem_addr;
    logic               mem_read_q;
    logic               mem_write_q;
    logic [dmem_aw-1:0] mem_index_q;
    logic [31:0]        mem_data_q;
    logic [4:0]         mem_dest_q;
    logic [31:0]        dmem [`ISSUE_DMEM_WORDS];
    issue_pkg::wb_t     mul_s1;
    issue_pkg::wb_t     mul_s2;

    // ALU/misc, result written at the next edge
    assign alu_b = iss.sel_imm ? iss.imm_ext : iss.reg_b;

    always_comb begin
        case (iss.alu_op)
            issue_pkg::alu_add: alu_result = iss.reg_a + alu_b;
            issue_pkg::alu_sub: alu_result = iss.reg_a - alu_b;
            issue_pkg::alu_and: alu_result = iss.reg_a & alu_b;
            issue_pkg::alu_or:  alu_result = iss.reg_a | alu_b;
            issue_pkg::alu_slt: alu_result = {31'd0, $signed(iss.reg_a) < $signed(alu_b)};
            issue_pkg::alu_sll: alu_result = iss.reg_b << iss.shamt;
            default:            alu_result = 32'h0000_0000;
        endcase
    end

    assign wb_alu.valid = (iss.unit == issue_pkg::unit_alu) && iss.write_reg;
    assign wb_alu.addr  = iss.dest;
    assign wb_alu.data  = alu_result;

    // Memory unit, address is a word index that wraps at the array depth
    assign mem_addr = iss.reg_a + iss.imm_ext;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end else begin
            mem_read_q  <= (iss.unit == issue_pkg::unit_mem) && iss.read_mem && iss.write_reg;
            mem_write_q <= (iss.unit == issue_pkg::unit_mem) && iss.write_mem;
        end
    end

    always_ff @(posedge clock) begin
        mem_index_q <= mem_addr[dmem_aw-1:0];
        mem_data_q  <= iss.reg_b;
        mem_dest_q  <= iss.dest;
        if (mem_write_q) begin
            dmem[mem_index_q] <= mem_data_q;
        end
    end

    // Stores never write back
    assign wb_mem.valid = mem_read_q;
    assign wb_mem.addr  = mem_dest_q;
    assign wb_mem.data  = dmem[mem_index_q];

    // Multiplier, two product stages then the register file write
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            mul_s1 <= '0;
            mul_s2 <= '0;
        end else begin
            mul_s1.valid <= (iss.unit == issue_pkg::unit_mul) && iss.write_reg;
            mul_s1.addr  <= iss.dest;
            mul_s1.data  <= iss.reg_a * iss.reg_b;  // low word only
            mul_s2       <= mul_s1;
        end
    end

    assign wb_mul = mul_s2;

endmodule

`default_nettype wire

// ==== verilog/issue_defines.svh ====
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// Data memory size in 32-bit words, word index wraps at this depth
`define ISSUE_DMEM_WORDS 64

// Architectural integer registers
`define ISSUE_NUM_REGS 32

`endif

// ==== verilog/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    // Primary opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    // Function codes under op_special
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_mult = 6'b011000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_slt  = 6'b101010;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } instr_i_t;

    // One instruction word, read as R-format or I-format
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    // unit_none marks an issue bubble
    typedef enum logic [1:0] {
        unit_alu,
        unit_mem,
        unit_mul,
        unit_none
    } unit_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll
    } alu_op_t;

    typedef struct packed {
        logic        valid;
        logic [5:0]  op;
        logic [5:0]  funct;
        logic [4:0]  addr_a;
        logic [4:0]  addr_b;
        logic        uses_b;
        logic [4:0]  dest;
        logic        write_reg;
        alu_op_t     alu_op;
        logic        sel_imm;
        logic [31:0] imm_ext;
        logic [4:0]  shamt;
        logic        read_mem;
        logic        write_mem;
    } dec_iss_t;

    typedef struct packed {
        unit_t       unit;
        alu_op_t     alu_op;
        logic        sel_imm;
        logic [31:0] imm_ext;
        logic [4:0]  shamt;
        logic [31:0] reg_a;
        logic [31:0] reg_b;
        logic [4:0]  dest;
        logic        write_reg;
        logic        read_mem;
        logic        write_mem;
    } iss_ex_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_t;

endpackage

`default_nettype wire

// ==== verilog/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  issue_pkg::dec_iss_t  dec,
    input  logic [31:0]          reg_a,
    input  logic [31:0]          reg_b,
    input  issue_pkg::wb_t       wb_alu,
    input  issue_pkg::wb_t       wb_mem,
    input  issue_pkg::wb_t       wb_mul,
    output logic                 stall,
    output issue_pkg::iss_ex_t   iss
);

    logic             pending_a;
    logic             pending_b;
    logic             pending_dest;
    logic             issue_go;
    issue_pkg::unit_t unit_sel;

    scoreboard u_scoreboard (
        .clock        (clock),
        .reset        (reset),
        .addr_a       (dec.addr_a),
        .addr_b       (dec.addr_b),
        .addr_dest    (dec.dest),
        .pending_a    (pending_a),
        .pending_b    (pending_b),
        .pending_dest (pending_dest),
        .issue_write  (issue_go && dec.write_reg),
        .issue_addr   (dec.dest),
        .issue_unit   (unit_sel),
        .wb_alu       (wb_alu),
        .wb_mem       (wb_mem),
        .wb_mul       (wb_mul)
    );

    // RAW on rs or rt, WAW on the destination
    assign stall = dec.valid &&
                   (pending_a ||
                    (dec.uses_b && pending_b) ||
                    (dec.write_reg && pending_dest));

    assign issue_go = dec.valid && !stall;

    always_comb begin
        if (dec.op == issue_pkg::op_lw || dec.op == issue_pkg::op_sw) begin
            unit_sel = issue_pkg::unit_mem;
        end else if (dec.op == issue_pkg::op_special && dec.funct == issue_pkg::fn_mult) begin
            unit_sel = issue_pkg::unit_mul;
        end else begin
            unit_sel = issue_pkg::unit_alu;
        end
    end

    // Payload follows decode every cycle, the unit field marks a bubble
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            iss      <= '0;
            iss.unit <= issue_pkg::unit_none;
        end else begin
            iss.unit      <= issue_go ? unit_sel : issue_pkg::unit_none;
            iss.alu_op    <= dec.alu_op;
            iss.sel_imm   <= dec.sel_imm;
            iss.imm_ext   <= dec.imm_ext;
            iss.shamt     <= dec.shamt;
            iss.reg_a     <= reg_a;
            iss.reg_b     <= reg_b;
            iss.dest      <= dec.dest;
            iss.write_reg <= dec.write_reg;
            iss.read_mem  <= dec.read_mem;
            iss.write_mem <= dec.write_mem;
        end
    end

    // A stalled instruction waits unchanged in decode and leaves a bubble for execute
    assert property (@(posedge clock) disable iff (!reset)
        stall |=> iss.unit == issue_pkg::unit_none && dec.valid && $stable(dec));

endmodule

`default_nettype wire

// ==== verilog/pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_top (
    input  logic               clock,
    input  logic               reset,
    input  issue_pkg::instr_t  instr,
    input  logic               instr_valid,
    output logic               stall,
    output issue_pkg::wb_t     wb_alu,
    output issue_pkg::wb_t     wb_mem,
    output issue_pkg::wb_t     wb_mul,
    input  logic [4:0]         debug_addr,
    output logic [31:0]        debug_data
);

    logic [4:0]          addr_a;
    logic [4:0]          addr_b;
    logic [31:0]         data_a;
    logic [31:0]         data_b;
    logic [31:0]         reg_a;
    logic [31:0]         reg_b;
    issue_pkg::dec_iss_t dec;
    issue_pkg::iss_ex_t  iss;

    decode_stage u_decode (
        .clock       (clock),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .addr_a      (addr_a),
        .addr_b      (addr_b),
        .data_a      (data_a),
        .data_b      (data_b),
        .dec         (dec),
        .reg_a       (reg_a),
        .reg_b       (reg_b)
    );

    register_file u_regfile (
        .clock      (clock),
        .reset      (reset),
        .addr_a     (addr_a),
        .addr_b     (addr_b),
        .data_a     (data_a),
        .data_b     (data_b),
        .wb_alu     (wb_alu),
        .wb_mem     (wb_mem),
        .wb_mul     (wb_mul),
        .debug_addr (debug_addr),
        .debug_data (debug_data)
    );

    issue_stage u_issue (
        .clock  (clock),
        .reset  (reset),
        .dec    (dec),
        .reg_a  (reg_a),
        .reg_b  (reg_b),
        .wb_alu (wb_alu),
        .wb_mem (wb_mem),
        .wb_mul (wb_mul),
        .stall  (stall),
        .iss    (iss)
    );

    execute_units u_execute (
        .clock  (clock),
        .reset  (reset),
        .iss    (iss),
        .wb_alu (wb_alu),
        .wb_mem (wb_mem),
        .wb_mul (wb_mul)
    );

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_defines.svh"

module register_file (
    input  logic             clock,
    input  logic             reset,
    input  logic [4:0]       addr_a,
    input  logic [4:0]       addr_b,
    output logic [31:0]      data_a,
    output logic [31:0]      data_b,
    input  issue_pkg::wb_t   wb_alu,
    input  issue_pkg::wb_t   wb_mem,
    input  issue_pkg::wb_t   wb_mul,
    input  logic [4:0]       debug_addr,
    output logic [31:0]      debug_data
);

    logic [31:0] regs [`ISSUE_NUM_REGS];

    // One write port per functional unit
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else begin
            if (wb_alu.valid) begin
                regs[wb_alu.addr] <= wb_alu.data;
            end
            if (wb_mem.valid) begin
                regs[wb_mem.addr] <= wb_mem.data;
            end
            if (wb_mul.valid) begin
                regs[wb_mul.addr] <= wb_mul.data;
            end
        end
    end

    // r0 always reads as zero
    assign data_a     = (addr_a == 5'd0) ? 32'h0000_0000 : regs[addr_a];
    assign data_b     = (addr_b == 5'd0) ? 32'h0000_0000 : regs[addr_b];
    assign debug_data = (debug_addr == 5'd0) ? 32'h0000_0000 : regs[debug_addr];

    // The scoreboard's WAW stall keeps writeback ports on distinct registers
    assert property (@(posedge clock) disable iff (!reset)
        !(wb_alu.valid && wb_mem.valid && wb_alu.addr == wb_mem.addr) &&
        !(wb_alu.valid && wb_mul.valid && wb_alu.addr == wb_mul.addr) &&
        !(wb_mem.valid && wb_mul.valid && wb_mem.addr == wb_mul.addr));

endmodule

`default_nettype wire

// ==== verilog/scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "issue_defines.svh"

module scoreboard (
    input  logic              clock,
    input  logic              reset,
    input  logic [4:0]        addr_a,
    input  logic [4:0]        addr_b,
    input  logic [4:0]        addr_dest,
    output logic              pending_a,
    output logic              pending_b,
    output logic              pending_dest,
    input  logic              issue_write,
    input  logic [4:0]        issue_addr,
    input  issue_pkg::unit_t  issue_unit,
    input  issue_pkg::wb_t    wb_alu,
    input  issue_pkg::wb_t    wb_mem,
    input  issue_pkg::wb_t    wb_mul
);

    logic [`ISSUE_NUM_REGS-1:0] pending;
    issue_pkg::unit_t           owner [`ISSUE_NUM_REGS];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pending <= '0;
            for (int i = 0; i < `ISSUE_NUM_REGS; i++) begin
                owner[i] <= issue_pkg::unit_none;
            end
        end else begin
            if (issue_write) begin
                pending[issue_addr] <= 1'b1;
                owner[issue_addr]   <= issue_unit;
            end
            // Only the owning unit releases an entry
            if (wb_alu.valid && owner[wb_alu.addr] == issue_pkg::unit_alu) begin
                pending[wb_alu.addr] <= 1'b0;
            end
            if (wb_mem.valid && owner[wb_mem.addr] == issue_pkg::unit_mem) begin
                pending[wb_mem.addr] <= 1'b0;
            end
            if (wb_mul.valid && owner[wb_mul.addr] == issue_pkg::unit_mul) begin
                pending[wb_mul.addr] <= 1'b0;
            end
        end
    end

    assign pending_a    = pending[addr_a];
    assign pending_b    = pending[addr_b];
    assign pending_dest = pending[addr_dest];

    // A writeback must target a register that waits on that same unit
    assert property (@(posedge clock) disable iff (!reset)
        (!wb_alu.valid || (pending[wb_alu.addr] && owner[wb_alu.addr] == issue_pkg::unit_alu)) &&
        (!wb_mem.valid || (pending[wb_mem.addr] && owner[wb_mem.addr] == issue_pkg::unit_mem)) &&
        (!wb_mul.valid || (pending[wb_mul.addr] && owner[wb_mul.addr] == issue_pkg::unit_mul)));

endmodule

`default_nettype wire
